// File: Makefile
# Verilator build and run of the tcb subsystem testbench

VERILATOR ?= verilator
TOP       ?= tcb_top_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
+incdir+logic
logic/tcb_pkg.sv
logic/tcb_if.sv
logic/tcb_register_backpressure.sv
logic/tcb_decoder.sv
logic/tcb_memory.sv
logic/tcb_status_regs.sv
logic/tcb_top.sv
testbench/tcb_top_tb.sv

// File: logic/tcb_decoder.sv
// tcb address decoder routing requests to memory, status block or error response
`timescale 1ns/1ps
`include "tcb_defs.svh"

module tcb_decoder (
  input logic sub,
  input logic rst_n,
  tcb_if.trg  up,
  tcb_if.man  mem,
  tcb_if.man  sts
);
  import tcb_pkg::*;

  // offsets into each region
  tcb_adr_t mem_off;
  tcb_adr_t sts_off;

  // current and pending select
  tcb_sel_t sel;
  tcb_sel_t rsp_sel;
  logic     rsp_vld_q;
  logic     sel_rsp_vld;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  // unsigned wrap puts addresses below base out of range
  assign mem_off = up.adr - tcb_adr_t'(`TCB_MEM_BASE);
  assign sts_off = up.adr - tcb_adr_t'(`TCB_STS_BASE);

  always_comb begin
    if (mem_off < tcb_adr_t'(`TCB_MEM_SIZE)) begin
      sel = SEL_MEM;
    end else if (sts_off < tcb_adr_t'(`TCB_STS_SIZE)) begin
      sel = SEL_STS;
    end else begin
      sel = SEL_ERR;
    end
  end

  // request fan-out, subordinates see local offsets
  assign mem.vld = up.vld && (sel == SEL_MEM);
  assign mem.wen = up.wen;
  assign mem.adr = mem_off;
  assign mem.ben = up.ben;
  assign mem.wdt = up.wdt;

  assign sts.vld = up.vld && (sel == SEL_STS);
  assign sts.wen = up.wen;
  assign sts.adr = sts_off;
  assign sts.ben = up.ben;
  assign sts.wdt = up.wdt;

  // ready from the selected target, unmapped always ready
  always_comb begin
    case (sel)
      SEL_MEM: up.rdy = mem.rdy;
      SEL_STS: up.rdy = sts.rdy;
      default: up.rdy = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // response tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld_q <= 1'b0;
      rsp_sel   <= SEL_ERR;
    end else begin
      rsp_vld_q <= up.vld && up.rdy;
      if (up.vld && up.rdy) begin
        rsp_sel <= sel;
      end
    end
  end

  // response mux, error target answers itself
  always_comb begin
    case (rsp_sel)
      SEL_MEM: begin
        sel_rsp_vld = mem.rsp_vld;
        up.rdt      = mem.rdt;
        up.err      = mem.err;
      end
      SEL_STS: begin
        sel_rsp_vld = sts.rsp_vld;
        up.rdt      = sts.rdt;
        up.err      = sts.err;
      end
      default: begin
        sel_rsp_vld = 1'b1;
        up.rdt      = '0;
        up.err      = 1'b1;
      end
    endcase
  end

  assign up.rsp_vld = rsp_vld_q && sel_rsp_vld;

endmodule : tcb_decoder

// File: logic/tcb_defs.svh
// tcb shared constants: bus widths, address map, response timing and status id
`ifndef TCB_DEFS_SVH
`define TCB_DEFS_SVH

// bus widths
`define TCB_ADR_W 16
`define TCB_DAT_W 32
`define TCB_BEN_W 4

// memory region, 4 KiB of words
`define TCB_MEM_BASE 16'h0000
`define TCB_MEM_SIZE 16'h1000

// status register region
`define TCB_STS_BASE 16'h1000
`define TCB_STS_SIZE 16'h0100

// cycles from accepted request to response
`define TCB_RSP_DLY 1

// read-only id at status offset 8
`define TCB_STATUS_ID 32'h7CB0_0001

`endif

// File: logic/tcb_if.sv
// tcb interface: valid/ready request with one-cycle in-order response
`timescale 1ns/1ps

interface tcb_if;
  import tcb_pkg::*;

  // request handshake
  logic     vld;
  logic     rdy;

  // request payload
  logic     wen;
  tcb_adr_t adr;
  tcb_ben_t ben;
  tcb_dat_t wdt;

  // response, one cycle after transfer
  logic     rsp_vld;
  tcb_dat_t rdt;
  logic     err;

  // manager side
  modport man (
    output vld,
    output wen,
    output adr,
    output ben,
    output wdt,
    input  rdy,
    input  rsp_vld,
    input  rdt,
    input  err
  );

  // subordinate side, mirror of man
  modport trg (
    input  vld,
    input  wen,
    input  adr,
    input  ben,
    input  wdt,
    output rdy,
    output rsp_vld,
    output rdt,
    output err
  );

endinterface : tcb_if

// File: logic/tcb_memory.sv
// tcb memory subordinate with byte enables and registered read data
`timescale 1ns/1ps

module tcb_memory #(
  parameter int DEPTH = 1024
) (
  input logic sub,
  input logic rst_n,
  tcb_if.trg  bus
);
  import tcb_pkg::*;

  // word index width
  localparam int AW = $clog2(DEPTH);

  // storage
  tcb_dat_t       mem [DEPTH];

  logic [AW-1:0]  idx;
  tcb_dat_t       rdt_q;
  logic           rsp_vld_q;
  logic           xfer;

  // byte address to word index
  assign idx  = bus.adr[2 +: AW];

  // never stalls
  assign bus.rdy = 1'b1;
  assign xfer    = bus.vld && bus.rdy;

  ////////////////////////////////////////////////////////////
  // array access
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sub) begin
    if (xfer && bus.wen) begin
      // only enabled bytes
      for (int i = 0; i < $bits(tcb_ben_t); i++) begin
        if (bus.ben[i]) begin
          mem[idx][8*i +: 8] <= bus.wdt[8*i +: 8];
        end
      end
    end
    // writes answer with zero data
    if (xfer) begin
      rdt_q <= bus.wen ? '0 : mem[idx];
    end
  end

  // response strobe
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= xfer;
    end
  end

  assign bus.rsp_vld = rsp_vld_q;
  assign bus.rdt     = rdt_q;
  assign bus.err     = 1'b0;

endmodule : tcb_memory

// File: logic/tcb_pkg.sv
// tcb package: bus vector types and decoder target select
`include "tcb_defs.svh"

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // bus vectors
  ////////////////////////////////////////////////////////////

  // byte address
  typedef logic [`TCB_ADR_W-1:0] tcb_adr_t;

  // read and write data
  typedef logic [`TCB_DAT_W-1:0] tcb_dat_t;

  // one enable per data byte
  typedef logic [`TCB_BEN_W-1:0] tcb_ben_t;

  ////////////////////////////////////////////////////////////
  // decoder select
  ////////////////////////////////////////////////////////////

  // which subordinate owns a request
  typedef enum logic [1:0] {
    SEL_MEM,
    SEL_STS,
    SEL_ERR
  } tcb_sel_t;

endpackage : tcb_pkg

// File: logic/tcb_register_backpressure.sv
// tcb skid buffer registering the ready path between manager and decoder
`timescale 1ns/1ps

module tcb_register_backpressure (
  input logic sub,
  input logic rst_n,
  tcb_if.trg  up,
  tcb_if.man  dn
);
  import tcb_pkg::*;

  // held request, payload only
  logic     tmp_wen;
  tcb_adr_t tmp_adr;
  tcb_ben_t tmp_ben;
  tcb_dat_t tmp_wdt;

  // registered upstream ready
  logic     rdy_q;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  // capture when upstream transfers but downstream stalls
  always_ff @(posedge sub) begin
    if (up.vld && rdy_q && !dn.rdy) begin
      tmp_wen <= up.wen;
      tmp_adr <= up.adr;
      tmp_ben <= up.ben;
      tmp_wdt <= up.wdt;
    end
  end

  // held request keeps vld high until it goes through
  assign dn.vld = rdy_q ? up.vld : 1'b1;
  assign dn.wen = rdy_q ? up.wen : tmp_wen;
  assign dn.adr = rdy_q ? up.adr : tmp_adr;
  assign dn.ben = rdy_q ? up.ben : tmp_ben;
  assign dn.wdt = rdy_q ? up.wdt : tmp_wdt;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // drop on a stalled request, rise once the buffer drains
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      rdy_q <= 1'b1;
    end else if (rdy_q) begin
      rdy_q <= !(up.vld && !dn.rdy);
    end else begin
      rdy_q <= dn.rdy;
    end
  end

  assign up.rdy = rdy_q;

  // responses untouched
  assign up.rsp_vld = dn.rsp_vld;
  assign up.rdt     = dn.rdt;
  assign up.err     = dn.err;

endmodule : tcb_register_backpressure

// File: logic/tcb_status_regs.sv
// tcb status block: scratch register, write counter, id, stall after each write
`timescale 1ns/1ps
`include "tcb_defs.svh"

module tcb_status_regs (
  input logic sub,
  input logic rst_n,
  tcb_if.trg  bus
);
  import tcb_pkg::*;

  tcb_dat_t scratch_q;
  tcb_dat_t wr_cnt_q;
  logic     stall_q;
  logic     xfer;

  // offset decode
  logic     hit_scr;
  logic     hit_cnt;
  logic     hit_id;

  // response registers
  logic     rsp_vld_q;
  tcb_dat_t rdt_q;
  logic     err_q;

  assign hit_scr = (bus.adr == tcb_adr_t'(0));
  assign hit_cnt = (bus.adr == tcb_adr_t'(4));
  assign hit_id  = (bus.adr == tcb_adr_t'(8));

  // one idle cycle after every write
  assign bus.rdy = !stall_q;
  assign xfer    = bus.vld && bus.rdy;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      scratch_q <= '0;
      wr_cnt_q  <= '0;
      stall_q   <= 1'b0;
    end else begin
      stall_q <= xfer && bus.wen;
      // counts every accepted write, read-only offsets too
      if (xfer && bus.wen) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
      // scratch, byte by byte
      if (xfer && bus.wen && hit_scr) begin
        for (int i = 0; i < $bits(tcb_ben_t); i++) begin
          if (bus.ben[i]) begin
            scratch_q[8*i +: 8] <= bus.wdt[8*i +: 8];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= xfer;
    end
  end

  // read mux sampled at transfer, writes return zero
  always_ff @(posedge sub) begin
    if (xfer) begin
      err_q <= !(hit_scr || hit_cnt || hit_id);
      if (bus.wen) begin
        rdt_q <= '0;
      end else if (hit_scr) begin
        rdt_q <= scratch_q;
      end else if (hit_cnt) begin
        rdt_q <= wr_cnt_q;
      end else if (hit_id) begin
        rdt_q <= `TCB_STATUS_ID;
      end else begin
        rdt_q <= '0;
      end
    end
  end

  assign bus.rsp_vld = rsp_vld_q;
  assign bus.rdt     = rdt_q;
  assign bus.err     = err_q;

endmodule : tcb_status_regs

// File: logic/tcb_top.sv
// tcb subsystem top: skid buffer, decoder, memory and status block
`timescale 1ns/1ps
`include "tcb_defs.svh"

module tcb_top (
  input  logic              sub,
  input  logic              rst_n,
  // request
  input  logic              vld,
  output logic              rdy,
  input  logic              wen,
  input  tcb_pkg::tcb_adr_t adr,
  input  tcb_pkg::tcb_ben_t ben,
  input  tcb_pkg::tcb_dat_t wdt,
  // response
  output logic              rsp_vld,
  output tcb_pkg::tcb_dat_t rdt,
  output logic              err
);

  // external port bundle, slice output, decoder outputs
  tcb_if bus_in  ();
  tcb_if bus_up  ();
  tcb_if bus_mem ();
  tcb_if bus_sts ();

  // pins onto the manager side of the slice
  assign bus_in.vld = vld;
  assign bus_in.wen = wen;
  assign bus_in.adr = adr;
  assign bus_in.ben = ben;
  assign bus_in.wdt = wdt;

  assign rdy     = bus_in.rdy;
  assign rsp_vld = bus_in.rsp_vld;
  assign rdt     = bus_in.rdt;
  assign err     = bus_in.err;

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////

  tcb_register_backpressure slice_i (
    .sub   (sub),
    .rst_n (rst_n),
    .up    (bus_in.trg),
    .dn    (bus_up.man)
  );

  tcb_decoder dec_i (
    .sub   (sub),
    .rst_n (rst_n),
    .up    (bus_up.trg),
    .mem   (bus_mem.man),
    .sts   (bus_sts.man)
  );

  // depth in words from region size
  tcb_memory #(
    .DEPTH (`TCB_MEM_SIZE / 4)
  ) mem_i (
    .sub   (sub),
    .rst_n (rst_n),
    .bus   (bus_mem.trg)
  );

  tcb_status_regs sts_i (
    .sub   (sub),
    .rst_n (rst_n),
    .bus   (bus_sts.trg)
  );

endmodule : tcb_top

// File: testbench/tcb_top_tb.sv
// tcb subsystem testbench: directed and random traffic checked against a reference model
`timescale 1ns/1ps
`include "tcb_defs.svh"

module tcb_top_tb;
  import tcb_pkg::*;

  // requests per test: 10, 9, 7, 32, 6, then 16 fill plus the random ones
  localparam int       RAND_REQS  = 200;
  localparam int       NUM_REQS   = 10 + 9 + 7 + 32 + 6 + 16 + RAND_REQS;
  localparam int       MAX_CYCLES = 2 * NUM_REQS + 100;
  localparam int       MEM_WORDS  = int'(`TCB_MEM_SIZE) / 4;
  localparam tcb_adr_t STS        = `TCB_STS_BASE;
  // random memory traffic stays inside a prefilled window
  localparam tcb_adr_t WIN_BASE   = 16'h0400;
  localparam int       WIN_WORDS  = 16;

  logic     sub = 1'b0;
  logic     rst_n;
  logic     vld;
  logic     rdy;
  logic     wen;
  tcb_adr_t adr;
  tcb_ben_t ben;
  tcb_dat_t wdt;
  logic     rsp_vld;
  tcb_dat_t rdt;
  logic     err;

  // reference state
  tcb_dat_t mem_model [MEM_WORDS];
  tcb_dat_t scratch_model = '0;
  tcb_dat_t wr_cnt_model  = '0;

  // expected responses in acceptance order
  tcb_dat_t pend_rdt [$];
  logic     pend_err [$];
  tcb_adr_t pend_adr [$];

  int issued     = 0;
  int accepted   = 0;
  int responded  = 0;
  int checks     = 0;
  int chk_errors = 0;
  int seq_errors = 0;
  int cycles     = 0;
  int tests      = 0;
  int err_mark   = 0;

  logic [15:0] lfsr_state = 16'd39038;

  tcb_top dut_i (
    .sub     (sub),
    .rst_n   (rst_n),
    .vld     (vld),
    .rdy     (rdy),
    .wen     (wen),
    .adr     (adr),
    .ben     (ben),
    .wdt     (wdt),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .err     (err)
  );

  always #50 sub = ~sub;

  ////////////////////////////////////////////////////////////
  // reference model and random source
  ////////////////////////////////////////////////////////////

  // expected response from the address map, updates model state
  function automatic void expected_response(
    input  logic     w,
    input  tcb_adr_t a,
    input  tcb_ben_t b,
    input  tcb_dat_t d,
    output tcb_dat_t exp_rdt,
    output logic     exp_err
  );
    int ai;
    int off;
    ai      = int'(a);
    exp_rdt = '0;
    exp_err = 1'b0;
    if (ai >= int'(`TCB_MEM_BASE) && ai < int'(`TCB_MEM_BASE) + int'(`TCB_MEM_SIZE)) begin
      // word index, byte lanes under ben
      off = (ai - int'(`TCB_MEM_BASE)) / 4;
      if (w) begin
        for (int i = 0; i < $bits(tcb_ben_t); i++) begin
          if (b[i]) begin
            mem_model[off][8*i +: 8] = d[8*i +: 8];
          end
        end
      end else begin
        exp_rdt = mem_model[off];
      end
    end else if (ai >= int'(`TCB_STS_BASE) &&
                 ai < int'(`TCB_STS_BASE) + int'(`TCB_STS_SIZE)) begin
      off     = ai - int'(`TCB_STS_BASE);
      exp_err = !(off == 0 || off == 4 || off == 8);
      if (w) begin
        // every write counts, whatever the offset
        wr_cnt_model = wr_cnt_model + 1;
        if (off == 0) begin
          for (int i = 0; i < $bits(tcb_ben_t); i++) begin
            if (b[i]) begin
              scratch_model[8*i +: 8] = d[8*i +: 8];
            end
          end
        end
      end else if (off == 0) begin
        exp_rdt = scratch_model;
      end else if (off == 4) begin
        exp_rdt = wr_cnt_model;
      end else if (off == 8) begin
        exp_rdt = `TCB_STATUS_ID;
      end
    end else begin
      // unmapped, zero data
      exp_err = 1'b1;
    end
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // bus monitor and comparison
  ////////////////////////////////////////////////////////////

  always @(posedge sub) begin : check_bus
    tcb_dat_t e_rdt;
    logic     e_err;
    tcb_adr_t e_adr;
    // response first, its entry was queued on an earlier edge
    if (rst_n && rsp_vld) begin
      // every pulse counts, stray ones too
      responded++;
      if (pend_rdt.size() == 0) begin
        $display("response at %0t ns arrived with no request outstanding", $time);
        chk_errors++;
      end else begin
        e_rdt = pend_rdt.pop_front();
        e_err = pend_err.pop_front();
        e_adr = pend_adr.pop_front();
        checks++;
        assert (rdt === e_rdt && err === e_err) else begin
          $display("error at %0t ns: adr %h returned rdt %h err %b, expected rdt %h err %b",
                   $time, e_adr, rdt, err, e_rdt, e_err);
          chk_errors++;
        end
      end
    end
    // accepted request
    if (rst_n && vld && rdy) begin
      expected_response(wen, adr, ben, wdt, e_rdt, e_err);
      pend_rdt.push_back(e_rdt);
      pend_err.push_back(e_err);
      pend_adr.push_back(adr);
      accepted++;
    end
  end

  always @(posedge sub) begin : watchdog
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // driver tasks
  ////////////////////////////////////////////////////////////

  // hold the request until rdy, rdy is registered so negedge is safe
  task automatic send_request(input logic w, input tcb_adr_t a, input tcb_ben_t b,
                              input tcb_dat_t d);
    issued++;
    vld = 1'b1;
    wen = w;
    adr = a;
    ben = b;
    wdt = d;
    @(negedge sub);
    while (!rdy) begin
      @(negedge sub);
    end
    @(posedge sub);
    #1;
    vld = 1'b0;
  endtask

  task automatic write_word(input tcb_adr_t a, input tcb_ben_t b, input tcb_dat_t d);
    send_request(1'b1, a, b, d);
  endtask

  task automatic read_word(input tcb_adr_t a);
    send_request(1'b0, a, '1, '0);
  endtask

  // returns just after a rising edge, ready for the next drive
  task automatic wait_idle();
    while (pend_rdt.size() != 0) begin
      @(posedge sub);
      #1;
    end
  endtask

  task automatic end_test(input string name);
    wait_idle();
    tests++;
    $display("test %0d %s: %0d errors", tests, name, chk_errors + seq_errors - err_mark);
    err_mark = chk_errors + seq_errors;
  endtask

  // full write, two partial merges, read-back after each merge
  task automatic check_merge(input tcb_adr_t a, input tcb_dat_t d);
    write_word(a, 4'b1111, d);
    write_word(a, 4'b0101, ~d);
    read_word(a);
    write_word(a, 4'b1000, 32'h5A00_0000);
    read_word(a);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : run_tests
    tcb_adr_t   a;
    tcb_dat_t   d;
    tcb_ben_t   b;
    logic       w;
    logic [1:0] region;
    rst_n = 1'b0;
    vld   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    ben   = '0;
    wdt   = '0;
    repeat (3) @(posedge sub);
    #1;
    rst_n = 1'b1;

    // both ends of the memory region
    check_merge(`TCB_MEM_BASE, 32'h0123_4567);
    check_merge(tcb_adr_t'(`TCB_MEM_BASE + `TCB_MEM_SIZE - 16'h4), 32'h89AB_CDEF);
    end_test("memory byte enables");

    // scratch under byte enables, id, undefined offsets
    write_word(STS, 4'b1111, 32'h0123_4567);
    read_word(STS);
    write_word(STS, 4'b0011, 32'hFFFF_AAAA);
    read_word(STS);
    write_word(STS, 4'b0100, 32'h00CC_0000);
    read_word(STS);
    read_word(STS + 16'h8);
    read_word(STS + 16'hC);
    read_word(STS + 16'hFC);
    end_test("status registers");

    // read-only offsets still count
    for (int n = 0; n < 2; n++) begin
      write_word(STS, 4'b1111, rand_bits(32));
      write_word(STS + 16'h4, 4'b1111, rand_bits(32));
      write_word(STS + 16'h8, 4'b1111, rand_bits(32));
    end
    read_word(STS + 16'h4);
    end_test("write counter");

    // each write stalls the next request
    for (int n = 0; n < 8; n++) begin
      write_word(STS, 4'b1111, rand_bits(32));
      write_word(STS + 16'h4, 4'b1111, rand_bits(32));
      read_word(STS);
      read_word(STS + 16'h4);
    end
    wait_idle();
    // driven, accepted and answered must all agree
    assert (issued == accepted && responded == accepted) else begin
      $display("%0d requests driven, %0d accepted, %0d responses returned",
               issued, accepted, responded);
      seq_errors++;
    end
    end_test("back-pressure");

    // just past the status region and far above it
    write_word(16'h1100, 4'b1111, 32'hFFFF_FFFF);
    read_word(16'h1100);
    write_word(16'h2000, 4'b1111, 32'hFFFF_FFFF);
    read_word(16'h2000);
    write_word(16'hFFFC, 4'b1111, 32'hFFFF_FFFF);
    read_word(16'hFFFC);
    end_test("unmapped addresses");

    // known data in the window before random reads
    for (int n = 0; n < WIN_WORDS; n++) begin
      write_word(WIN_BASE + tcb_adr_t'(4 * n), 4'b1111, rand_bits(32));
    end
    for (int n = 0; n < RAND_REQS; n++) begin
      region = 2'(rand_bits(2));
      w      = (rand_bits(1) != 0);
      b      = tcb_ben_t'(rand_bits(4));
      d      = rand_bits(32);
      case (region)
        // offsets 0 to 12, the last one undefined
        2'd2:    a = STS + tcb_adr_t'(rand_bits(2) << 2);
        2'd3:    a = tcb_adr_t'(`TCB_STS_BASE + `TCB_STS_SIZE) + tcb_adr_t'(rand_bits(12) << 2);
        default: a = WIN_BASE + tcb_adr_t'(rand_bits(4) << 2);
      endcase
      send_request(w, a, b, d);
    end
    end_test("random traffic");

    $display("summary: %0d tests, %0d accepted, %0d responses, %0d checks, %0d errors",
             tests, accepted, responded, checks, chk_errors + seq_errors);
    if (chk_errors + seq_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tcb_top_tb
